// ==== Bender.yml ====
package:
  name: control_register

sources:
  - include_dirs:
      - .
    files:
      - cr_pkg.sv
      - cr_perf_counters.sv
      - cr_thread_status.sv
      - cr_uncoherent_map.sv
      - cr_config_regs.sv
      - cr_read_mux.sv
      - cr_host_port.sv
      - control_register.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_control_register.sv

// ==== control_register.sv ====
// Core reads are combinational and unqualified by valid, so the core ignores cr_result when idle
`timescale 1ns/1ps
`default_nettype none

`include "cr_macros.svh"

module control_register
	import cr_pkg::*;
#(
	parameter logic [15:0] tile_id_par = 16'd0,
	parameter logic [15:0] core_id_par = 16'd0
) (
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire logic                          enable,
	input  wire wb_req_t                       wb_req,
	output wb_rsp_t                            wb_rsp,
	input  wire core_op_t                      core_op,
	output logic [`CR_REGISTER_SIZE-1:0]       cr_result,
	input  wire logic [`CR_ADDRESS_SIZE-1:0]   effective_address,
	output logic                               uncoherent_area_hit,
	input  wire logic                          ldst_miss,
	input  wire logic                          inst_miss,
	input  wire logic [`CR_THREAD_NUMB-1:0]    tc_thread_en,
	input  wire logic [`CR_THREAD_NUMB-1:0]    bc_release_thread,
	output logic                               ctrl_cache_wt
);

	logic [`CR_COUNTER_WIDTH-1:0]          global_counter;
	logic [`CR_REGISTER_SIZE-1:0]          miss_data_cnt;
	logic [`CR_REGISTER_SIZE-1:0]          miss_instr_cnt;
	thread_status_e [`CR_THREAD_NUMB-1:0]  status;
	logic [`CR_REGISTER_SIZE-1:0]          argc_q;
	logic [`CR_REGISTER_SIZE-1:0]          argv_q;
	cpu_ctrl_t                             cpu_ctrl_q;
	logic [`CR_DEBUG_REG_NUM-1:0][`CR_REGISTER_SIZE-1:0] debug_q;
	cr_view_t                              view;
	cr_write_t                             core_write;
	cr_write_t                             host_write;
	cr_index_e                             host_index;
	thread_id_t                            host_thread;
	logic [`CR_REGISTER_SIZE-1:0]          host_rdata;

	// Only a valid write instruction reaches the register file
	always_comb begin
		core_write.en     = core_op.valid && core_op.write;
		core_write.index  = core_op.index;
		core_write.thread = core_op.thread;
		core_write.data   = core_op.data;
	end

	always_comb begin
		view.global_counter = global_counter;
		view.miss_data      = miss_data_cnt;
		view.miss_instr     = miss_instr_cnt;
		view.thread_en      = tc_thread_en;
		view.status         = status;
		view.argc           = argc_q;
		view.argv           = argv_q;
		view.cpu_ctrl       = cpu_ctrl_q;
		view.debug          = debug_q;
	end

	cr_perf_counters u_perf (
		.clk            (clk),
		.reset          (reset),
		.enable         (enable),
		.ldst_miss      (ldst_miss),
		.inst_miss      (inst_miss),
		.global_counter (global_counter),
		.miss_data      (miss_data_cnt),
		.miss_instr     (miss_instr_cnt)
	);

	cr_thread_status u_status (
		.clk               (clk),
		.reset             (reset),
		.core_write        (core_write),
		.bc_release_thread (bc_release_thread),
		.status            (status)
	);

	cr_uncoherent_map u_umap (
		.clk                 (clk),
		.reset               (reset),
		.core_write          (core_write),
		.effective_address   (effective_address),
		.uncoherent_area_hit (uncoherent_area_hit)
	);

	cr_config_regs u_config (
		.clk        (clk),
		.reset      (reset),
		.host_write (host_write),
		.core_write (core_write),
		.argc       (argc_q),
		.argv       (argv_q),
		.cpu_ctrl   (cpu_ctrl_q),
		.debug      (debug_q)
	);

	cr_host_port u_host (
		.clk         (clk),
		.reset       (reset),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.read_data   (host_rdata),
		.host_write  (host_write),
		.host_index  (host_index),
		.host_thread (host_thread)
	);

	cr_read_mux core_mux (
		.view    (view),
		.index   (cr_index_e'(core_op.index)),
		.thread  (core_op.thread),
		.tile_id (tile_id_par),
		.core_id (core_id_par),
		.rdata   (cr_result)
	);

	// Host side uses the thread from the request address
	cr_read_mux host_mux (
		.view    (view),
		.index   (host_index),
		.thread  (host_thread),
		.tile_id (tile_id_par),
		.core_id (core_id_par),
		.rdata   (host_rdata)
	);

	assign ctrl_cache_wt = cpu_ctrl_q.cache_wt;

endmodule

`default_nettype wire

// ==== cr_config_regs.sv ====
// Host writes win over core writes to the same index and only the host can write cpu_ctrl
`timescale 1ns/1ps
`default_nettype none

`include "cr_macros.svh"

module cr_config_regs
	import cr_pkg::*;
(
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire cr_write_t                     host_write,
	input  wire cr_write_t                     core_write,
	output logic [`CR_REGISTER_SIZE-1:0]       argc,
	output logic [`CR_REGISTER_SIZE-1:0]       argv,
	output cpu_ctrl_t                          cpu_ctrl,
	output logic [`CR_DEBUG_REG_NUM-1:0][`CR_REGISTER_SIZE-1:0] debug
);

	// Slot 0 is argc, slot 1 is argv, the rest are the debug registers
	localparam int num_slots = 2 + `CR_DEBUG_REG_NUM;

	logic [`CR_REGISTER_SIZE-1:0] slot_q [num_slots];

	for (genvar s = 0; s < num_slots; s++) begin : g_slot
		localparam int slot_index = (s == 0) ? int'(cr_pkg::argc) :
			(s == 1) ? int'(cr_pkg::argv) : int'(cr_pkg::debug_base) + s - 2;

		logic host_hit;
		logic core_hit;

		assign host_hit = host_write.en && host_write.index == slot_index;
		assign core_hit = core_write.en && core_write.index == slot_index;

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				slot_q[s] <= '0;
			end else if (host_hit) begin
				slot_q[s] <= host_write.data;
			end else if (core_hit) begin
				slot_q[s] <= core_write.data;
			end
		end
	end

	assign argc = slot_q[0];
	assign argv = slot_q[1];

	always_comb begin
		for (int d = 0; d < `CR_DEBUG_REG_NUM; d++) begin
			debug[d] = slot_q[d + 2];
		end
	end

	// Cache policy and interrupt control written by the host
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cpu_ctrl <= '0;
		end else if (host_write.en && host_write.index == cr_pkg::cpu_ctrl) begin
			cpu_ctrl <= cpu_ctrl_t'(host_write.data);
		end
	end

endmodule

`default_nettype wire

// ==== cr_host_port.sv ====
// Wishbone classic slave with 32-bit accesses only, no byte selects and no error or retry
`timescale 1ns/1ps
`default_nettype none

`include "cr_macros.svh"

module cr_host_port
	import cr_pkg::*;
(
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire wb_req_t                       wb_req,
	output wb_rsp_t                            wb_rsp,
	input  wire logic [`CR_REGISTER_SIZE-1:0]  read_data,
	output cr_write_t                          host_write,
	output cr_index_e                          host_index,
	output thread_id_t                         host_thread
);

	logic                         accept;
	logic                         ack_q;
	logic [`CR_REGISTER_SIZE-1:0] dat_q;

	// A pending ack blocks the next sample, so a held strobe gets an ack every other cycle
	assign accept = wb_req.cyc && wb_req.stb && !ack_q;

	assign host_index  = cr_index_e'(wb_req.adr[`CR_INDEX_BITS-1:0]);
	assign host_thread = wb_req.adr[16 +: $bits(thread_id_t)];

	always_comb begin
		host_write.en     = accept && wb_req.we;
		host_write.index  = wb_req.adr[`CR_INDEX_BITS-1:0];
		host_write.thread = host_thread;
		host_write.data   = wb_req.dat;
	end

	// Read data is captured with the same edge that commits a write
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q <= 1'b0;
			dat_q <= '0;
		end else begin
			ack_q <= accept;
			if (accept) begin
				dat_q <= read_data;
			end
		end
	end

	assign wb_rsp = '{ack: ack_q, dat: dat_q};

	ack_never_back_to_back: assert property (
		@(posedge clk) disable iff (reset) wb_rsp.ack |=> !wb_rsp.ack
	);

endmodule

`default_nettype wire

// ==== cr_macros.svh ====
// Thread count must stay a power of two because thread fields are sized by its log2
`ifndef CR_MACROS_SVH
`define CR_MACROS_SVH

// Datapath widths
`define CR_REGISTER_SIZE 32
`define CR_COUNTER_WIDTH 64
`define CR_ADDRESS_SIZE 32
`define CR_INDEX_BITS 8

// Replicated resources
`define CR_THREAD_NUMB 4
`define CR_DEBUG_REG_NUM 4

// Uncoherent regions compare only the top address bits
`define CR_UMAP_SIZE 4
`define CR_UMAP_BITS 8

`endif

// ==== cr_perf_counters.sv ====
// All counters wrap silently and only reset clears them
`timescale 1ns/1ps
`default_nettype none

`include "cr_macros.svh"

module cr_perf_counters (
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire logic                          enable,
	input  wire logic                          ldst_miss,
	input  wire logic                          inst_miss,
	output logic [`CR_COUNTER_WIDTH-1:0]       global_counter,
	output logic [`CR_REGISTER_SIZE-1:0]       miss_data,
	output logic [`CR_REGISTER_SIZE-1:0]       miss_instr
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			global_counter <= '0;
			miss_data <= '0;
			miss_instr <= '0;
		end else begin
			// Cycles while the core is enabled
			if (enable) begin
				global_counter <= global_counter + 1'b1;
			end
			// One count per cycle with the miss line high
			if (ldst_miss) begin
				miss_data <= miss_data + 1'b1;
			end
			if (inst_miss) begin
				miss_instr <= miss_instr + 1'b1;
			end
		end
	end

	gcounter_frozen_when_disabled: assert property (
		@(posedge clk) disable iff (reset) !enable |=> $stable(global_counter)
	);

endmodule

`default_nettype wire

// ==== cr_pkg.sv ====
// Register indices are fixed by software and debug registers take consecutive indices from 16
`default_nettype none

`include "cr_macros.svh"

package cr_pkg;

	typedef logic [$clog2(`CR_THREAD_NUMB)-1:0] thread_id_t;

	typedef enum logic [`CR_INDEX_BITS-1:0] {
		tile_id         = 0,
		core_id         = 1,
		thread_id       = 2,
		global_id       = 3,
		gcounter_low    = 4,
		gcounter_high   = 5,
		thread_en       = 6,
		miss_data       = 7,
		miss_instr      = 8,
		thread_status   = 9,
		argc            = 10,
		argv            = 11,
		thread_numb     = 12,
		cpu_ctrl        = 13,
		uncoherence_map = 14,
		debug_base      = 16
	} cr_index_e;

	typedef enum logic [1:0] {
		thread_idle            = 0,
		thread_running         = 1,
		thread_waiting_barrier = 2,
		thread_end             = 3
	} thread_status_e;

	typedef struct packed {
		logic                          cache_wt;
		logic                          interrupt_enable;
		logic                          supervisor;
		logic                          interrupt_pending;
		logic                          interrupt_trigger_mode;
		logic [`CR_REGISTER_SIZE-6:0]  unused;
	} cpu_ctrl_t;

	// Control register instruction from the pipeline
	typedef struct packed {
		logic                          valid;
		logic                          write;
		thread_id_t                    thread;
		logic [`CR_INDEX_BITS-1:0]     index;
		logic [`CR_REGISTER_SIZE-1:0]  data;
	} core_op_t;

	// Index in adr[7:0], thread in adr[17:16]
	typedef struct packed {
		logic                          cyc;
		logic                          stb;
		logic                          we;
		logic [`CR_ADDRESS_SIZE-1:0]   adr;
		logic [`CR_REGISTER_SIZE-1:0]  dat;
	} wb_req_t;

	typedef struct packed {
		logic                          ack;
		logic [`CR_REGISTER_SIZE-1:0]  dat;
	} wb_rsp_t;

	typedef struct packed {
		logic [`CR_COUNTER_WIDTH-1:0]                         global_counter;
		logic [`CR_REGISTER_SIZE-1:0]                         miss_data;
		logic [`CR_REGISTER_SIZE-1:0]                         miss_instr;
		logic [`CR_THREAD_NUMB-1:0]                           thread_en;
		thread_status_e [`CR_THREAD_NUMB-1:0]                 status;
		logic [`CR_REGISTER_SIZE-1:0]                         argc;
		logic [`CR_REGISTER_SIZE-1:0]                         argv;
		cpu_ctrl_t                                            cpu_ctrl;
		logic [`CR_DEBUG_REG_NUM-1:0][`CR_REGISTER_SIZE-1:0]  debug;
	} cr_view_t;

	typedef struct packed {
		logic                          en;
		logic [`CR_INDEX_BITS-1:0]     index;
		thread_id_t                    thread;
		logic [`CR_REGISTER_SIZE-1:0]  data;
	} cr_write_t;

	// Same layout as the low 17 bits of a map write
	typedef struct packed {
		logic [`CR_UMAP_BITS-1:0]      start_addr;
		logic [`CR_UMAP_BITS-1:0]      end_addr;
		logic                          valid;
	} umap_entry_t;

endpackage

`default_nettype wire

// ==== cr_read_mux.sv ====
// Write-only and unknown indices read as zero
`timescale 1ns/1ps
`default_nettype none

`include "cr_macros.svh"

module cr_read_mux
	import cr_pkg::*;
(
	input  wire cr_view_t                      view,
	input  wire cr_index_e                     index,
	input  wire thread_id_t                    thread,
	input  wire logic [15:0]                   tile_id,
	input  wire logic [15:0]                   core_id,
	output logic [`CR_REGISTER_SIZE-1:0]       rdata
);

	localparam int debug_bits = $clog2(`CR_DEBUG_REG_NUM);
	localparam int core_bits  = 16 - $bits(thread_id_t);

	logic [`CR_INDEX_BITS-1:0] debug_offset;
	logic                      debug_hit;

	// Debug registers sit in a contiguous block above debug_base
	assign debug_offset = index - cr_pkg::debug_base;
	assign debug_hit    = index >= cr_pkg::debug_base
		&& debug_offset < `CR_INDEX_BITS'(`CR_DEBUG_REG_NUM);

	always_comb begin
		rdata = '0;
		case (index)
			cr_pkg::tile_id:       rdata = `CR_REGISTER_SIZE'(tile_id);
			cr_pkg::core_id:       rdata = `CR_REGISTER_SIZE'(core_id);
			cr_pkg::thread_id:     rdata = `CR_REGISTER_SIZE'(thread);
			// Tile in the top half, thread in the low bits
			cr_pkg::global_id:     rdata = {tile_id, core_id[core_bits-1:0], thread};
			cr_pkg::gcounter_low:  rdata = view.global_counter[`CR_REGISTER_SIZE-1:0];
			cr_pkg::gcounter_high: rdata = view.global_counter[`CR_COUNTER_WIDTH-1 -: 32];
			cr_pkg::thread_en:     rdata = `CR_REGISTER_SIZE'(view.thread_en);
			cr_pkg::miss_data:     rdata = view.miss_data;
			cr_pkg::miss_instr:    rdata = view.miss_instr;
			cr_pkg::thread_status: rdata = `CR_REGISTER_SIZE'(view.status[thread]);
			cr_pkg::argc:          rdata = view.argc;
			cr_pkg::argv:          rdata = view.argv;
			cr_pkg::thread_numb:   rdata = `CR_REGISTER_SIZE'(`CR_THREAD_NUMB);
			cr_pkg::cpu_ctrl:      rdata = view.cpu_ctrl;
			cr_pkg::uncoherence_map: rdata = '0;
			default: begin
				if (debug_hit) begin
					rdata = view.debug[debug_offset[debug_bits-1:0]];
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== cr_thread_status.sv ====
// A low release bit reports the thread as waiting at the barrier whatever its stored status
`timescale 1ns/1ps
`default_nettype none

`include "cr_macros.svh"

module cr_thread_status
	import cr_pkg::*;
(
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire cr_write_t                     core_write,
	input  wire logic [`CR_THREAD_NUMB-1:0]    bc_release_thread,
	output thread_status_e [`CR_THREAD_NUMB-1:0] status
);

	thread_status_e status_q [`CR_THREAD_NUMB];
	logic           status_write;

	assign status_write = core_write.en && core_write.index == thread_status;

	for (genvar t = 0; t < `CR_THREAD_NUMB; t++) begin : g_thread
		// Only the thread that issued the write updates its own status
		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				status_q[t] <= thread_idle;
			end else if (status_write && core_write.thread == thread_id_t'(t)) begin
				status_q[t] <= thread_status_e'(core_write.data[$bits(thread_status_e)-1:0]);
			end
		end
	end

	// Barrier override
	always_comb begin
		for (int t = 0; t < `CR_THREAD_NUMB; t++) begin
			status[t] = bc_release_thread[t] ? status_q[t] : thread_waiting_barrier;
		end
	end

endmodule

`default_nettype wire

// ==== cr_uncoherent_map.sv ====
// Regions compare only the top address bits and bounds are inclusive on both ends
`timescale 1ns/1ps
`default_nettype none

`include "cr_macros.svh"

module cr_uncoherent_map
	import cr_pkg::*;
(
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire cr_write_t                     core_write,
	input  wire logic [`CR_ADDRESS_SIZE-1:0]   effective_address,
	output logic                               uncoherent_area_hit
);

	localparam int region_bits = $clog2(`CR_UMAP_SIZE);

	umap_entry_t                   region_q [`CR_UMAP_SIZE];
	logic [`CR_UMAP_SIZE-1:0]      region_hit;
	logic [`CR_UMAP_BITS-1:0]      address_top;
	logic                          map_write;
	logic [region_bits-1:0]        region_sel;

	// Write word layout
	// [18:17] region, [16:9] start, [8:1] end, [0] valid
	assign map_write   = core_write.en && core_write.index == uncoherence_map;
	assign region_sel  = core_write.data[$bits(umap_entry_t) +: region_bits];
	assign address_top = effective_address[`CR_ADDRESS_SIZE-1 -: `CR_UMAP_BITS];

	for (genvar r = 0; r < `CR_UMAP_SIZE; r++) begin : g_region
		// Reset clears only the valid bit of each region
		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				region_q[r].valid <= 1'b0;
			end else if (map_write && region_sel == region_bits'(r)) begin
				region_q[r] <= core_write.data[$bits(umap_entry_t)-1:0];
			end
		end

		assign region_hit[r] = region_q[r].valid
			&& address_top >= region_q[r].start_addr
			&& address_top <= region_q[r].end_addr;
	end

	assign uncoherent_area_hit = |region_hit;

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
cr_pkg.sv
cr_perf_counters.sv
cr_thread_status.sv
cr_uncoherent_map.sv
cr_config_regs.sv
cr_read_mux.sv
cr_host_port.sv
control_register.sv
tb_control_register.sv

// ==== tb_control_register.sv ====
// Random testbench with a fixed LCG seed and a cycle model, stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

`include "cr_macros.svh"

module tb_control_register
	import cr_pkg::*;
();

	localparam int clk_period = 100;
	localparam int reset_cycles = 16;
	localparam logic [15:0] tile_id_value = 16'h0a3c;
	localparam logic [15:0] core_id_value = 16'h5b17;
	// Host accesses per phase plus the core-only cycles of the map phase
	localparam int planned_transactions = 20 + 40 + 30 + 30 + 200 + 40;
	localparam int watchdog_cycles = planned_transactions * 10 + reset_cycles + 10;

	logic clk;
	logic reset;
	logic enable;
	wb_req_t wb_req;
	wb_req_t wb_next;
	wb_rsp_t wb_rsp;
	core_op_t core_op;
	logic [31:0] cr_result;
	logic [31:0] effective_address;
	logic uncoherent_area_hit;
	logic ldst_miss;
	logic inst_miss;
	logic [`CR_THREAD_NUMB-1:0] tc_thread_en;
	logic [`CR_THREAD_NUMB-1:0] bc_release_thread;
	logic ctrl_cache_wt;

	// Stimulus controls
	logic [31:0] lcg_state;
	logic quiet;
	logic release_random;
	logic core_writes;
	logic [7:0] core_pool [$];
	logic [7:0] host_pool [$];

	// Reference model state
	logic [63:0] m_gcounter;
	logic [31:0] m_miss_data;
	logic [31:0] m_miss_instr;
	logic [31:0] m_argc;
	logic [31:0] m_argv;
	logic [31:0] m_cpu_ctrl;
	logic [31:0] m_debug [`CR_DEBUG_REG_NUM];
	logic [1:0] m_status [`CR_THREAD_NUMB];
	logic [7:0] m_start [`CR_UMAP_SIZE];
	logic [7:0] m_end [`CR_UMAP_SIZE];
	logic m_valid [`CR_UMAP_SIZE];
	logic m_ack;

	control_register #(
		.tile_id_par (tile_id_value),
		.core_id_par (core_id_value)
	) dut (
		.clk                 (clk),
		.reset               (reset),
		.enable              (enable),
		.wb_req              (wb_req),
		.wb_rsp              (wb_rsp),
		.core_op             (core_op),
		.cr_result           (cr_result),
		.effective_address   (effective_address),
		.uncoherent_area_hit (uncoherent_area_hit),
		.ldst_miss           (ldst_miss),
		.inst_miss           (inst_miss),
		.tc_thread_en        (tc_thread_en),
		.bc_release_thread   (bc_release_thread),
		.ctrl_cache_wt       (ctrl_cache_wt)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(watchdog_cycles * clk_period);
		stop_with_error("run timed out before all transactions completed");
	end

	task automatic stop_with_error(input string msg);
		$display("TEST FAILED");
		$display("%s", msg);
		$fatal(1);
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] model_read(input logic [7:0] idx, input logic [1:0] thr);
		logic [31:0] value;
		value = '0;
		case (idx)
			tile_id:       value = {16'b0, tile_id_value};
			core_id:       value = {16'b0, core_id_value};
			thread_id:     value = {30'b0, thr};
			global_id:     value = {tile_id_value, core_id_value[13:0], thr};
			gcounter_low:  value = m_gcounter[31:0];
			gcounter_high: value = m_gcounter[63:32];
			thread_en:     value = {28'b0, tc_thread_en};
			miss_data:     value = m_miss_data;
			miss_instr:    value = m_miss_instr;
			thread_status: value = {30'b0, bc_release_thread[thr] ? m_status[thr] : 2'd2};
			argc:          value = m_argc;
			argv:          value = m_argv;
			thread_numb:   value = 32'd4;
			cpu_ctrl:      value = m_cpu_ctrl;
			default: begin
				if (idx >= 8'd16 && idx < 8'd20) begin
					value = m_debug[idx[1:0]];
				end
			end
		endcase
		return value;
	endfunction

	function automatic logic model_hit(input logic [31:0] addr);
		logic hit;
		hit = 1'b0;
		for (int r = 0; r < `CR_UMAP_SIZE; r++) begin
			if (m_valid[r] && addr[31:24] >= m_start[r] && addr[31:24] <= m_end[r]) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// Model follows the inputs sampled at each rising edge
	always @(posedge clk or posedge reset) begin : reference_model
		logic host_we;
		logic core_we;
		logic [1:0] region;
		if (reset) begin
			m_gcounter <= '0;
			m_miss_data <= '0;
			m_miss_instr <= '0;
			m_argc <= '0;
			m_argv <= '0;
			m_cpu_ctrl <= '0;
			m_ack <= 1'b0;
			for (int i = 0; i < 4; i++) begin
				m_debug[i] <= '0;
				m_status[i] <= 2'd0;
				m_valid[i] <= 1'b0;
				m_start[i] <= '0;
				m_end[i] <= '0;
			end
		end else begin
			host_we = wb_req.cyc && wb_req.stb && !m_ack && wb_req.we;
			core_we = core_op.valid && core_op.write;
			region = core_op.data[18:17];
			m_ack <= wb_req.cyc && wb_req.stb && !m_ack;
			m_gcounter <= m_gcounter + 64'(enable);
			m_miss_data <= m_miss_data + 32'(ldst_miss);
			m_miss_instr <= m_miss_instr + 32'(inst_miss);
			if (host_we && wb_req.adr[7:0] == argc) begin
				m_argc <= wb_req.dat;
			end else if (core_we && core_op.index == argc) begin
				m_argc <= core_op.data;
			end
			if (host_we && wb_req.adr[7:0] == argv) begin
				m_argv <= wb_req.dat;
			end else if (core_we && core_op.index == argv) begin
				m_argv <= core_op.data;
			end
			for (int d = 0; d < 4; d++) begin
				if (host_we && wb_req.adr[7:0] == 8'(16 + d)) begin
					m_debug[d] <= wb_req.dat;
				end else if (core_we && core_op.index == 8'(16 + d)) begin
					m_debug[d] <= core_op.data;
				end
			end
			if (host_we && wb_req.adr[7:0] == cpu_ctrl) begin
				m_cpu_ctrl <= wb_req.dat;
			end
			if (core_we && core_op.index == thread_status) begin
				m_status[core_op.thread] <= core_op.data[1:0];
			end
			if (core_we && core_op.index == uncoherence_map) begin
				m_start[region] <= core_op.data[16:9];
				m_end[region] <= core_op.data[8:1];
				m_valid[region] <= core_op.data[0];
			end
		end
	end

	task automatic check_cycle();
		if (core_op.valid && !core_op.write) begin
			assert (cr_result == model_read(core_op.index, core_op.thread)) else
				stop_with_error($sformatf("error at %0t: cr_result expected %h got %h",
					$time, model_read(core_op.index, core_op.thread), cr_result));
		end
		assert (uncoherent_area_hit == model_hit(effective_address)) else
			stop_with_error($sformatf("error at %0t: uncoherent_area_hit expected %b got %b",
				$time, model_hit(effective_address), uncoherent_area_hit));
		assert (ctrl_cache_wt == m_cpu_ctrl[31]) else
			stop_with_error($sformatf("error at %0t: ctrl_cache_wt expected %b got %b",
				$time, m_cpu_ctrl[31], ctrl_cache_wt));
	endtask

	// One cycle of stimulus on the falling edge, then the combinational checks
	task automatic advance();
		logic [31:0] r;
		@(negedge clk);
		wb_req = wb_next;
		r = next_rand();
		enable = quiet ? 1'b0 : r[31];
		ldst_miss = quiet ? 1'b0 : r[30];
		inst_miss = quiet ? 1'b0 : r[29];
		tc_thread_en = quiet ? '0 : r[28:25];
		bc_release_thread = release_random ? r[24:21] : '1;
		effective_address = next_rand();
		if (core_pool.size() == 0) begin
			core_op = '0;
		end else begin
			r = next_rand();
			core_op.valid = r[31] | r[30];
			core_op.write = r[29] & core_writes;
			core_op.thread = r[28:27];
			core_op.index = core_pool[r[23:16] % core_pool.size()];
			core_op.data = next_rand();
		end
		#1;
		check_cycle();
	endtask

	task automatic host_access(input logic we, input logic [7:0] idx, input logic [1:0] thr,
		input logic [31:0] data);
		logic [31:0] expected;
		int waited;
		wb_next.cyc = 1'b1;
		wb_next.stb = 1'b1;
		wb_next.we = we;
		wb_next.adr = {14'b0, thr, 8'b0, idx};
		wb_next.dat = data;
		advance();
		expected = model_read(idx, thr);
		waited = 0;
		do begin
			advance();
			waited++;
		end while (!wb_rsp.ack && waited < 8);
		assert (wb_rsp.ack) else
			stop_with_error("Wishbone ack never came for a host request");
		assert (wb_rsp.dat == expected) else
			stop_with_error($sformatf("error at %0t: wb_rsp.dat expected %h got %h (index %0d)",
				$time, expected, wb_rsp.dat, idx));
		wb_next = '0;
	endtask

	task automatic random_host_accesses(input int count, input logic writes);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			r = next_rand();
			host_access(writes & r[31], host_pool[r[23:16] % host_pool.size()], r[29:28],
				next_rand());
		end
	endtask

	initial begin
		lcg_state = 32'd39;
		reset = 1'b1;
		enable = 1'b0;
		wb_req = '0;
		wb_next = '0;
		core_op = '0;
		effective_address = '0;
		ldst_miss = 1'b0;
		inst_miss = 1'b0;
		tc_thread_en = '0;
		bc_release_thread = '1;
		quiet = 1'b1;
		release_random = 1'b0;
		core_writes = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (!ctrl_cache_wt && !wb_rsp.ack && wb_rsp.dat == '0) else
			stop_with_error("outputs are not cleared after reset");

		// Identity and reset values over every index up to the last debug register
		for (int i = 0; i < 20; i++) begin
			host_access(1'b0, 8'(i), 2'(next_rand() >> 30), '0);
		end

		// Host over core priority on argc, argv and the debug registers
		quiet = 1'b0;
		core_writes = 1'b1;
		core_pool = '{argc, argv, 8'd16, 8'd17, 8'd18, 8'd19};
		host_pool = core_pool;
		random_host_accesses(40, 1'b1);

		// Counters
		core_writes = 1'b0;
		core_pool = '{gcounter_low, gcounter_high, thread_en, miss_data, miss_instr};
		host_pool = core_pool;
		random_host_accesses(30, 1'b0);

		// Thread status with the barrier override
		release_random = 1'b1;
		core_writes = 1'b1;
		core_pool = '{thread_status};
		host_pool = core_pool;
		random_host_accesses(30, 1'b0);

		// Region programming and address lookups
		core_pool = '{uncoherence_map, uncoherence_map, argc};
		repeat (200) advance();

		// cpu_ctrl takes host writes only
		core_pool = '{cpu_ctrl, argv};
		host_pool = '{cpu_ctrl, cpu_ctrl, argc, 8'd17};
		for (int i = 0; i < 20; i++) begin
			random_host_accesses(1, 1'b1);
			host_access(1'b0, cpu_ctrl, 2'd0, '0);
		end

		@(negedge clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
